// ==== src/cacc_calc_pkg.sv ====
// widths, scalar types and stage structs for the int16 accumulate datapath

package cacc_calc_pkg;

  // ========================================
  // widths
  // ========================================

  // product sum from the mac array
  localparam int DATA_W  = 38;
  // operand and partial sum
  localparam int ACC_W   = 48;
  // final result after truncate and round
  localparam int OUT_W   = 32;
  // truncate amount
  localparam int TRUNC_W = 5;

  // ========================================
  // scalar types
  // ========================================

  typedef logic signed [DATA_W-1:0] cacc_data_t;
  typedef logic signed [ACC_W-1:0]  cacc_acc_t;
  typedef logic signed [OUT_W-1:0]  cacc_out_t;
  // shift amount, always non-negative
  typedef logic [TRUNC_W-1:0]       cacc_trunc_t;

  // ========================================
  // stage structs
  // ========================================

  // accumulate stage to output stage, 49 bits
  typedef struct packed {
    // 1 final, 0 partial
    logic      sel;
    // sum already clamped to 48 bits
    cacc_acc_t sum;
  } cacc_stage_t;

  // final result, 33 bits
  typedef struct packed {
    // rounded and clamped value
    cacc_out_t data;
    // set when the value was clamped
    logic      sat;
  } cacc_final_t;

endpackage

// ==== src/cacc_sum_add.sv ====
// accumulate stage: operand mask, wide signed add, 48-bit clamp and stage register

module cacc_sum_add (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  logic                       i_valid,
  input  logic                       i_sel,
  input  logic                       i_op_valid,
  input  cacc_calc_pkg::cacc_data_t  i_data,
  input  cacc_calc_pkg::cacc_acc_t   i_op,
  output logic                       o_stage_valid,
  output cacc_calc_pkg::cacc_stage_t o_stage
);

  import cacc_calc_pkg::*;

  // one extra bit holds any carry of a 48 + 38 bit signed add
  localparam int SUM_W = ACC_W + 1;

  // operand after the valid mask
  cacc_acc_t         op_masked;

  // both addends at full add width
  logic [SUM_W-1:0]  data_ext;
  logic [SUM_W-1:0]  op_ext;

  // raw sum, not yet clamped
  logic [SUM_W-1:0]  sum_wide;
  logic              sum_sign;
  logic              sum_ovf;

  // clamped sum and the struct that gets registered
  cacc_acc_t         sum_sat;
  cacc_stage_t       stage_nxt;

  // ========================================
  // operand mask and sign extension
  // ========================================

  // missing operand counts as zero
  assign op_masked = i_op_valid ? i_op : '0;

  // replicate msb up to the add width
  assign data_ext = {{(SUM_W-DATA_W){i_data[DATA_W-1]}}, i_data};
  assign op_ext   = {op_masked[ACC_W-1], op_masked};

  // ========================================
  // wide add
  // ========================================

  // two's complement add, bit pattern is sign safe
  assign sum_wide = data_ext + op_ext;

  // true sign sits in the extra top bit
  assign sum_sign = sum_wide[SUM_W-1];

  // overflow when the top two bits disagree
  assign sum_ovf  = sum_wide[SUM_W-1] ^ sum_wide[SUM_W-2];

  // ========================================
  // clamp to 48 bits
  // ========================================

  always_comb begin
    if (sum_ovf) begin
      // positive overflow gives 0x7fff..., negative gives 0x8000...
      sum_sat = {sum_sign, {(ACC_W-1){~sum_sign}}};
    end else begin
      sum_sat = sum_wide[ACC_W-1:0];
    end
  end

  // pack select and sum for the next stage
  always_comb begin
    stage_nxt.sel = i_sel;
    stage_nxt.sum = sum_sat;
  end

  // ========================================
  // stage register
  // ========================================

  // strobe, one cycle behind i_valid
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      o_stage_valid <= 1'b0;
    end else begin
      o_stage_valid <= i_valid;
    end
  end

  // payload only moves with a valid item
  always_ff @(posedge nvdla_core_clk) begin
    if (i_valid) begin
      o_stage <= stage_nxt;
    end
  end

endmodule

// ==== src/cacc_out_stage.sv ====
// output stage: partial/final routing, truncate shift, rounding, 32-bit clamp and output registers

module cacc_out_stage (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,
  input  logic                       i_stage_valid,
  input  cacc_calc_pkg::cacc_stage_t i_stage,
  input  cacc_calc_pkg::cacc_trunc_t i_cfg_truncate,
  output logic                       o_partial_valid,
  output cacc_calc_pkg::cacc_acc_t   o_partial_data,
  output logic                       o_final_valid,
  output cacc_calc_pkg::cacc_final_t o_final
);

  import cacc_calc_pkg::*;

  // fraction bits below the binary point, enough for the largest shift
  localparam int FRAC_W = 1 << TRUNC_W;
  localparam int EXT_W  = ACC_W + FRAC_W;

  // routed strobes
  logic              partial_vld;
  logic              final_vld;

  // shifted value with fraction bits appended
  logic signed [EXT_W-1:0] ext_pre;
  logic signed [EXT_W-1:0] ext_sft;
  cacc_acc_t         sft_int;
  logic              sum_sign;
  logic              guard;
  logic              sticky;
  logic              point5;

  // rounded value, one bit wider than the sum
  logic [ACC_W:0]    rnd_wide;
  logic [ACC_W-OUT_W+1:0] rnd_hi;
  logic              need_sat;
  cacc_out_t         sat_val;
  cacc_out_t         final_result;

  // final result registers
  cacc_out_t         final_data_q;
  logic              final_sat_q;

  // ========================================
  // routing by select bit
  // ========================================

  assign partial_vld = i_stage_valid & ~i_stage.sel;
  assign final_vld   = i_stage_valid &  i_stage.sel;

  // ========================================
  // truncate shift
  // ========================================

  assign sum_sign = i_stage.sum[ACC_W-1];

  // integer part on top, zero fraction below
  assign ext_pre = {i_stage.sum, {FRAC_W{1'b0}}};
  assign ext_sft = ext_pre >>> i_cfg_truncate;

  assign sft_int = ext_sft[EXT_W-1:FRAC_W];
  // first bit below the point
  assign guard   = ext_sft[FRAC_W-1];
  // any remaining shifted-out bit
  assign sticky  = |ext_sft[FRAC_W-2:0];

  // ========================================
  // rounding, ties away from zero
  // ========================================

  // positive tie rounds up; negative tie stays, i.e. moves away from zero
  assign point5 = guard & (~sum_sign | sticky);

  // sign extend by one bit, then add the half
  assign rnd_wide = {sft_int[ACC_W-1], sft_int} + {{ACC_W{1'b0}}, point5};

  // ========================================
  // clamp to 32 bits
  // ========================================

  // bits from the result msb upward must all match to fit
  assign rnd_hi   = rnd_wide[ACC_W:OUT_W-1];
  assign need_sat = ~((&rnd_hi) | ~(|rnd_hi));

  // rounding never crosses zero, so the sum sign picks the limit
  assign sat_val  = sum_sign ? {1'b1, {(OUT_W-1){1'b0}}} : {1'b0, {(OUT_W-1){1'b1}}};

  assign final_result = need_sat ? sat_val : rnd_wide[OUT_W-1:0];

  // ========================================
  // output registers
  // ========================================

  // strobes and flag
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      o_partial_valid <= 1'b0;
      o_final_valid   <= 1'b0;
      final_sat_q     <= 1'b0;
    end else begin
      o_partial_valid <= partial_vld;
      o_final_valid   <= final_vld;
      // flag only ever rides with a final strobe
      final_sat_q     <= final_vld & need_sat;
    end
  end

  // partial sum passes straight through
  always_ff @(posedge nvdla_core_clk) begin
    if (partial_vld) begin
      o_partial_data <= i_stage.sum;
    end
  end

  // rounded final value
  always_ff @(posedge nvdla_core_clk) begin
    if (final_vld) begin
      final_data_q <= final_result;
    end
  end

  assign o_final = '{data: final_data_q, sat: final_sat_q};

endmodule

// ==== src/cacc_calc_int16.sv ====
// top level for int16 accumulate: accumulate stage feeding the output stage

module cacc_calc_int16 (
  input  logic                       nvdla_core_clk,
  input  logic                       nvdla_core_rstn,

  // product sum side
  input  logic                       i_valid,
  input  cacc_calc_pkg::cacc_data_t  i_data,
  input  cacc_calc_pkg::cacc_acc_t   i_op,
  input  logic                       i_op_valid,
  input  logic                       i_sel,

  // static while items are in flight
  input  cacc_calc_pkg::cacc_trunc_t i_cfg_truncate,

  // partial sum out
  output logic                       o_partial_valid,
  output cacc_calc_pkg::cacc_acc_t   o_partial_data,

  // final result out
  output logic                       o_final_valid,
  output cacc_calc_pkg::cacc_final_t o_final
);

  import cacc_calc_pkg::*;

  // ========================================
  // stage-one to stage-two link
  // ========================================

  logic        stage_valid;
  cacc_stage_t stage;

  // add and 48-bit clamp, one cycle
  cacc_sum_add u_sum_add (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .i_valid         (i_valid),
    .i_sel           (i_sel),
    .i_op_valid      (i_op_valid),
    .i_data          (i_data),
    .i_op            (i_op),
    .o_stage_valid   (stage_valid),
    .o_stage         (stage)
  );

  // route, shift, round, clamp; one cycle
  cacc_out_stage u_out_stage (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .i_stage_valid   (stage_valid),
    .i_stage         (stage),
    .i_cfg_truncate  (i_cfg_truncate),
    .o_partial_valid (o_partial_valid),
    .o_partial_data  (o_partial_data),
    .o_final_valid   (o_final_valid),
    .o_final         (o_final)
  );

endmodule

// ==== testbench/cacc_calc_int16_asserts.sv ====
// concurrent checks on the output strobes and the bind into the top level

module cacc_calc_int16_asserts (
  input logic                       nvdla_core_clk,
  input logic                       nvdla_core_rstn,
  input logic                       i_in_valid,
  input logic                       i_partial_valid,
  input logic                       i_final_valid,
  input cacc_calc_pkg::cacc_final_t i_final
);

  // failed assertions so far, read by the testbench at the end
  int   fail_count = 0;

  // any output strobe this cycle
  logic any_out;

  assign any_out = i_partial_valid | i_final_valid;

  // ========================================
  // strobe rules
  // ========================================

  // an item leaves on one output only
  a_one_output: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      !(i_partial_valid && i_final_valid))
    else begin
      fail_count++;
      $error("partial and final strobes high in the same cycle");
    end

  // flag rides only with a final result
  a_sat_with_valid: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      i_final.sat |-> i_final_valid)
    else begin
      fail_count++;
      $error("saturation flag high without a final strobe");
    end

  // two register stages, fixed latency
  a_latency: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      i_in_valid |-> ##2 any_out)
    else begin
      fail_count++;
      $error("input item did not reach an output two cycles later");
    end

  // no strobe without an item behind it
  a_no_orphan: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
      any_out |-> $past(i_in_valid, 2))
    else begin
      fail_count++;
      $error("output strobe with no input item two cycles earlier");
    end

endmodule

bind cacc_calc_int16 cacc_calc_int16_asserts u_asserts (
  .nvdla_core_clk  (nvdla_core_clk),
  .nvdla_core_rstn (nvdla_core_rstn),
  .i_in_valid      (i_valid),
  .i_partial_valid (o_partial_valid),
  .i_final_valid   (o_final_valid),
  .i_final         (o_final)
);

// ==== testbench/tb_cacc_calc_int16.sv ====
// testbench: clock, reset, reference model, compare tasks, directed tests and watchdog

module tb_cacc_calc_int16;

  import cacc_calc_pkg::*;

  // ========================================
  // run constants
  // ========================================

  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 16;
  localparam int N_RANDOM      = 48;
  // directed items stay well under 64
  localparam int ITEM_BUDGET   = 64 + N_RANDOM;
  // drains between groups and pipeline fill
  localparam int MARGIN_CYCLES = 200;
  localparam int TIMEOUT = (RESET_CYCLES + ITEM_BUDGET + MARGIN_CYCLES) * CLK_PERIOD;

  // signed limits of the two clamps
  localparam longint ACC_MAX = (64'sd1 <<< (ACC_W - 1)) - 64'sd1;
  localparam longint ACC_MIN = -(64'sd1 <<< (ACC_W - 1));
  localparam longint OUT_MAX = (64'sd1 <<< (OUT_W - 1)) - 64'sd1;
  localparam longint OUT_MIN = -(64'sd1 <<< (OUT_W - 1));

  logic        nvdla_core_clk = 1'b0;
  logic        nvdla_core_rstn;
  logic        i_valid;
  cacc_data_t  i_data;
  cacc_acc_t   i_op;
  logic        i_op_valid;
  logic        i_sel;
  cacc_trunc_t i_cfg_truncate;
  logic        o_partial_valid;
  cacc_acc_t   o_partial_data;
  logic        o_final_valid;
  cacc_final_t o_final;

  // expected results in issue order, with the cycle they are due
  cacc_acc_t   exp_partial_q[$];
  cacc_final_t exp_final_q[$];
  int          partial_cyc_q[$];
  int          final_cyc_q[$];

  int          cyc = 0;
  int          err_value = 0;
  int          err_protocol = 0;
  int          err_assert = 0;
  integer      seed = 78985;

  // monitor scratch
  cacc_acc_t   mon_partial;
  cacc_final_t mon_final;
  int          mon_cyc;

  cacc_calc_int16 DUT (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .i_valid         (i_valid),
    .i_data          (i_data),
    .i_op            (i_op),
    .i_op_valid      (i_op_valid),
    .i_sel           (i_sel),
    .i_cfg_truncate  (i_cfg_truncate),
    .o_partial_valid (o_partial_valid),
    .o_partial_data  (o_partial_data),
    .o_final_valid   (o_final_valid),
    .o_final         (o_final)
  );

  always #(CLK_PERIOD / 2) nvdla_core_clk = ~nvdla_core_clk;

  // rising edges seen so far
  always @(posedge nvdla_core_clk) cyc <= cyc + 1;

  // ========================================
  // reference model
  // ========================================

  // add with missing operand as zero, then clamp to 48 bits
  function automatic cacc_acc_t model_sum(input cacc_data_t data, input cacc_acc_t op,
                                          input logic op_vld);
    longint s;
    s = longint'(data);
    if (op_vld) s = s + longint'(op);
    if (s > ACC_MAX) s = ACC_MAX;
    else if (s < ACC_MIN) s = ACC_MIN;
    return cacc_acc_t'(s);
  endfunction

  // round the magnitude to nearest, so ties move away from zero
  function automatic cacc_final_t model_final(input cacc_acc_t sum, input cacc_trunc_t trunc);
    longint      v;
    longint      mag;
    longint      q;
    int          t;
    cacc_final_t r;
    v   = longint'(sum);
    t   = int'(trunc);
    mag = (v < 0) ? -v : v;
    if (t != 0) mag = (mag + (64'sd1 <<< (t - 1))) >>> t;
    q     = (v < 0) ? -mag : mag;
    r.sat = 1'b0;
    if (q > OUT_MAX) begin
      q     = OUT_MAX;
      r.sat = 1'b1;
    end else if (q < OUT_MIN) begin
      q     = OUT_MIN;
      r.sat = 1'b1;
    end
    r.data = cacc_out_t'(q);
    return r;
  endfunction

  // ========================================
  // compare tasks
  // ========================================

  task automatic check_partial(input cacc_acc_t exp, input cacc_acc_t act);
    if (act !== exp) begin
      err_value++;
      $display("ERR t=%0t o_partial_data expected=%0d actual=%0d", $time, exp, act);
    end
  endtask

  task automatic check_final(input cacc_final_t exp, input cacc_final_t act);
    if (act.data !== exp.data) begin
      err_value++;
      $display("ERR t=%0t o_final.data expected=%0d actual=%0d", $time, exp.data, act.data);
    end
    if (act.sat !== exp.sat) begin
      err_value++;
      $display("ERR t=%0t o_final.sat expected=%0b actual=%0b", $time, exp.sat, act.sat);
    end
  endtask

  task automatic check_latency(input string name, input int due);
    if (cyc != due) begin
      err_protocol++;
      $display("%s arrived in cycle %0d but was due in cycle %0d", name, cyc, due);
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn && o_partial_valid) begin
      if (exp_partial_q.size() == 0) begin
        err_protocol++;
        $display("partial strobe at time %0t with no item outstanding", $time);
      end else begin
        mon_partial = exp_partial_q.pop_front();
        mon_cyc     = partial_cyc_q.pop_front();
        check_partial(mon_partial, o_partial_data);
        check_latency("o_partial_valid", mon_cyc);
      end
    end
    if (nvdla_core_rstn && o_final_valid) begin
      if (exp_final_q.size() == 0) begin
        err_protocol++;
        $display("final strobe at time %0t with no item outstanding", $time);
      end else begin
        mon_final = exp_final_q.pop_front();
        mon_cyc   = final_cyc_q.pop_front();
        check_final(mon_final, o_final);
        check_latency("o_final_valid", mon_cyc);
      end
    end
  end

  // ========================================
  // stimulus helpers
  // ========================================

  // one item for one cycle; the expectation is due two edges later
  task automatic send_item(input cacc_data_t data, input cacc_acc_t op, input logic op_vld,
                           input logic sel);
    cacc_acc_t sum;
    sum = model_sum(data, op, op_vld);
    if (sel) begin
      exp_final_q.push_back(model_final(sum, i_cfg_truncate));
      final_cyc_q.push_back(cyc + 2);
    end else begin
      exp_partial_q.push_back(sum);
      partial_cyc_q.push_back(cyc + 2);
    end
    i_valid    = 1'b1;
    i_data     = data;
    i_op       = op;
    i_op_valid = op_vld;
    i_sel      = sel;
    @(posedge nvdla_core_clk);
    #1;
    i_valid = 1'b0;
  endtask

  // wait until every outstanding item has been checked
  task automatic drain();
    do begin
      @(posedge nvdla_core_clk);
    end while (exp_partial_q.size() != 0 || exp_final_q.size() != 0);
    #1;
  endtask

  // ========================================
  // directed tests
  // ========================================

  task automatic test_partial_basic();
    $display("test_partial_basic");
    send_item(38'sd100, 48'sd23, 1'b1, 1'b0);
    send_item(-38'sd50, 48'sd20, 1'b1, 1'b0);
    send_item(38'sd5, -48'sd1000, 1'b1, 1'b0);
    send_item(38'sh1F_FFFF_FFFF, 48'sd1, 1'b1, 1'b0);
    send_item(38'sh1F_FFFF_FFFF, -48'sh20_0000_0000, 1'b1, 1'b0);
    // operand dropped, output is the sign-extended product sum
    send_item(-38'sd7, 48'sd12345, 1'b0, 1'b0);
    send_item(38'sh20_0000_0000, 48'sh7FFF_FFFF_FFFF, 1'b0, 1'b0);
    send_item(38'sd0, -48'sd1, 1'b1, 1'b0);
    drain();
  endtask

  task automatic test_partial_saturate();
    $display("test_partial_saturate");
    send_item(38'sd1, 48'sh7FFF_FFFF_FFFF, 1'b1, 1'b0);
    send_item(38'sh1F_FFFF_FFFF, 48'sh7FFF_FFFF_FFFF, 1'b1, 1'b0);
    send_item(-38'sd1, 48'sh8000_0000_0000, 1'b1, 1'b0);
    send_item(38'sh20_0000_0000, 48'sh8000_0000_0000, 1'b1, 1'b0);
    // exactly on the limits, no clamp
    send_item(38'sd5, 48'sh7FFF_FFFF_FFFA, 1'b1, 1'b0);
    send_item(-38'sd3, 48'sh8000_0000_0003, 1'b1, 1'b0);
    send_item(-38'sd1, 48'sh7FFF_FFFF_FFFF, 1'b1, 1'b0);
    drain();
  endtask

  task automatic test_final_round();
    $display("test_final_round");
    i_cfg_truncate = 5'd0;
    send_item(38'sd12345, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sd777, 48'sd0, 1'b0, 1'b1);
    drain();
    // 2.5, -2.5, -1.5 and 3.5 from an operand
    i_cfg_truncate = 5'd1;
    send_item(38'sd5, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sd5, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sd3, 48'sd0, 1'b0, 1'b1);
    send_item(38'sd4, 48'sd3, 1'b1, 1'b1);
    drain();
    // ties, then just under and just over a half
    i_cfg_truncate = 5'd8;
    send_item(38'sd384, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sd384, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sd640, 48'sd0, 1'b0, 1'b1);
    send_item(38'sd383, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sd385, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sd383, 48'sd0, 1'b0, 1'b1);
    drain();
    i_cfg_truncate = 5'd31;
    send_item(38'sh0_C000_0000, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sh0_C000_0000, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sh1_4000_0000, 48'sd0, 1'b0, 1'b1);
    send_item(38'sh0_3FFF_FFFF, 48'sd0, 1'b0, 1'b1);
    drain();
  endtask

  task automatic test_final_saturate();
    $display("test_final_saturate");
    i_cfg_truncate = 5'd0;
    send_item(38'sh0_8000_0000, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sh0_8000_0001, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sh0_8000_0000, 48'sd0, 1'b0, 1'b1);
    drain();
    // max minus a half only overflows once rounded
    i_cfg_truncate = 5'd1;
    send_item(38'sh0_FFFF_FFFF, 48'sd0, 1'b0, 1'b1);
    send_item(38'sh0_FFFF_FFFE, 48'sd0, 1'b0, 1'b1);
    send_item(-38'sh1_0000_0001, 48'sd0, 1'b0, 1'b1);
    drain();
    i_cfg_truncate = 5'd4;
    send_item(38'sd0, 48'sh7FFF_FFFF_FFFF, 1'b1, 1'b1);
    send_item(38'sd0, 48'sh8000_0000_0000, 1'b1, 1'b1);
    drain();
  endtask

  task automatic test_latency_mixed();
    cacc_data_t data;
    cacc_acc_t  op;
    int         rnd;
    $display("test_latency_mixed");
    i_cfg_truncate = 5'd20;
    repeat (N_RANDOM) begin
      rnd  = $random(seed);
      data = cacc_data_t'({$random(seed), $random(seed)});
      op   = cacc_acc_t'({$random(seed), $random(seed)});
      send_item(data, op, rnd[1], rnd[0]);
    end
    drain();
  endtask

  // ========================================
  // main sequence and watchdog
  // ========================================

  initial begin
    nvdla_core_rstn = 1'b0;
    i_valid         = 1'b0;
    i_data          = '0;
    i_op            = '0;
    i_op_valid      = 1'b0;
    i_sel           = 1'b0;
    i_cfg_truncate  = '0;
    repeat (RESET_CYCLES) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    @(posedge nvdla_core_clk);
    #1;
    test_partial_basic();
    test_partial_saturate();
    test_final_round();
    test_final_saturate();
    test_latency_mixed();
    err_assert = DUT.u_asserts.fail_count;
    $display("errors: value %0d, protocol %0d, assertion %0d",
             err_value, err_protocol, err_assert);
    if (err_value + err_protocol + err_assert == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("watchdog expired at time %0t, outputs stopped arriving", $time);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== cacc_calc.f ====
src/cacc_calc_pkg.sv
src/cacc_sum_add.sv
src/cacc_out_stage.sv
src/cacc_calc_int16.sv
testbench/cacc_calc_int16_asserts.sv
testbench/tb_cacc_calc_int16.sv

// ==== Makefile ====
# Verilator build for the int16 accumulate datapath

VERILATOR ?= verilator
TOP       := tb_cacc_calc_int16
FILELIST  := cacc_calc.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
# let the run reach the end after an assertion error
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
